/* filelist.f */
source/ex_pkg.sv
source/alu.sv
source/ex_lane.sv
source/mult_stage.sv
source/mult.sv
source/ex_arbiter.sv
source/ex_stage.sv
verif/tb_ex_stage.sv

/* source/alu.sv */
`timescale 1ns/1ps

module alu
  import ex_pkg::*;
(
  input  logic [XLEN-1:0] opa,
  input  logic [XLEN-1:0] opb,
  input  alu_func_t       func,
  output logic [XLEN-1:0] result
);

  logic [5:0] shamt;
  logic       signed_lt;
  logic       unsigned_lt;
  logic       equal;

  // Only the low six bits count for 64-bit shifts
  assign shamt = opb[5:0];

  assign signed_lt   = $signed(opa) < $signed(opb);
  assign unsigned_lt = opa < opb;
  assign equal       = opa == opb;

  always_comb begin
    case (func)
      ALU_ADDQ:   result = opa + opb;
      ALU_SUBQ:   result = opa - opb;
      ALU_AND:    result = opa & opb;
      ALU_BIC:    result = opa & ~opb;
      ALU_BIS:    result = opa | opb;
      ALU_ORNOT:  result = opa | ~opb;
      ALU_XOR:    result = opa ^ opb;
      ALU_EQV:    result = opa ^ ~opb;
      ALU_SRL:    result = opa >> shamt;
      ALU_SLL:    result = opa << shamt;
      ALU_SRA:    result = $signed(opa) >>> shamt;
      // Compares return 0 or 1 in bit zero
      ALU_CMPULT: result = {{(XLEN-1){1'b0}}, unsigned_lt};
      ALU_CMPEQ:  result = {{(XLEN-1){1'b0}}, equal};
      ALU_CMPULE: result = {{(XLEN-1){1'b0}}, unsigned_lt | equal};
      ALU_CMPLT:  result = {{(XLEN-1){1'b0}}, signed_lt};
      ALU_CMPLE:  result = {{(XLEN-1){1'b0}}, signed_lt | equal};
      // Marker value for codes outside the table
      default:    result = 64'hbad0_c0de_bad0_c0de;
    endcase
  end

endmodule

/* source/ex_arbiter.sv */
`timescale 1ns/1ps

module ex_arbiter
  import ex_pkg::*;
(
  input  lane_result_t lane_1,
  input  lane_result_t lane_2,
  input  mult_result_t mult_1,
  input  mult_result_t mult_2,
  input  mem_result_t  mem_in,
  output ex_result_t   result_1,
  output ex_result_t   result_2,
  output logic         stall_1,
  output logic         stall_2,
  output logic         hold_mult_2
);

  // ALU, branch or halt result of a lane, used when its bus is free
  function automatic ex_result_t from_lane(lane_result_t l);
    ex_result_t r;
    logic       is_halt;
    is_halt         = l.ir == HALT_INSTRUCTION;
    r.npc           = l.npc;
    r.dest_reg      = l.dest_reg;
    r.result        = l.alu_result;
    r.pht_idx       = l.pht_idx;
    if (l.branch_valid) begin
      r.mispredict    = l.mispredict;
      r.branch_result = l.branch_taken ? BRANCH_TAKEN : BRANCH_NOT_TAKEN;
      r.valid         = 1'b1;
    end else begin
      r.mispredict    = 1'b0;
      r.branch_result = is_halt ? BRANCH_HALT : BRANCH_NONE;
      r.valid         = is_halt | l.alu_valid;
    end
    return r;
  endfunction

  // Finished multiply, never a branch
  function automatic ex_result_t from_mult(mult_result_t m, lane_result_t l);
    ex_result_t r;
    r.npc           = m.tag.npc;
    r.dest_reg      = m.tag.dest_reg;
    r.result        = m.product;
    r.mispredict    = 1'b0;
    r.branch_result = BRANCH_NONE;
    r.pht_idx       = l.pht_idx;
    r.valid         = 1'b1;
    return r;
  endfunction

  // Bus 1: multiply first, then the lane
  always_comb begin
    stall_1 = mult_1.valid;
    if (mult_1.valid) begin
      result_1 = from_mult(mult_1, lane_1);
    end else begin
      result_1 = from_lane(lane_1);
    end
  end

  // Bus 2: load result first, then multiply, then the lane
  always_comb begin
    hold_mult_2 = 1'b0;
    stall_2     = mem_in.valid | mult_2.valid;
    if (mem_in.valid) begin
      // Freeze a multiply that would finish into the load
      hold_mult_2     = mult_2.valid;
      result_2        = from_mult(mult_2, lane_2);
      result_2.dest_reg = mem_in.tag;
      result_2.result   = mem_in.value;
    end else if (mult_2.valid) begin
      result_2 = from_mult(mult_2, lane_2);
    end else begin
      result_2 = from_lane(lane_2);
    end
  end

endmodule

/* source/ex_lane.sv */
`timescale 1ns/1ps

module ex_lane
  import ex_pkg::*;
(
  input  ex_issue_t    issue,
  input  logic         stall,
  output lane_result_t lane,
  output logic         mult_start,
  output mult_tag_t    mult_tag
);

  logic [XLEN-1:0] alu_result;
  logic            cond;
  logic            branch_valid;

  alu alu_inst (
    .opa    (issue.opa),
    .opb    (issue.opb),
    .func   (issue.alu_func),
    .result (alu_result)
  );

  // Branch condition tested against zero
  always_comb begin
    case (issue.br_func[1:0])
      2'b00:   cond = ~issue.opa[0];
      2'b01:   cond = issue.opa == '0;
      2'b10:   cond = issue.opa[XLEN-1];
      default: cond = issue.opa[XLEN-1] | (issue.opa == '0);
    endcase
  end

  assign branch_valid = issue.valid & issue.is_branch;

  // An empty slot never looks like a halt downstream
  assign lane.ir           = issue.valid ? issue.ir : '0;
  assign lane.npc          = issue.npc;
  assign lane.dest_reg     = issue.dest_reg;
  assign lane.alu_result   = alu_result;
  assign lane.alu_valid    = issue.valid & ~issue.is_branch & ~issue.is_mult;
  assign lane.branch_valid = branch_valid;
  assign lane.branch_taken = cond ^ issue.br_func[2];
  assign lane.mispredict   = branch_valid & ((cond ^ issue.br_func[2]) != issue.pred_taken);
  assign lane.pht_idx      = issue.pht_idx;

  // Held issue must not start the same multiply twice
  assign mult_start        = issue.valid & issue.is_mult & ~stall;
  assign mult_tag.npc      = issue.npc;
  assign mult_tag.dest_reg = issue.dest_reg;

endmodule

/* source/ex_pkg.sv */
package ex_pkg;

  // Datapath widths
  localparam int XLEN         = 64;
  localparam int REG_BITS     = 5;
  localparam int HISTORY_BITS = 5;

  // Multiplier geometry, one slice of the multiplier per stage
  localparam int SLICE_BITS  = 16;
  localparam int MULT_STAGES = 4;

  localparam logic [31:0] HALT_INSTRUCTION = 32'h0000_0555;

  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,
    ALU_SUBQ   = 5'h01,
    ALU_AND    = 5'h02,
    ALU_BIC    = 5'h03,
    ALU_BIS    = 5'h04,
    ALU_ORNOT  = 5'h05,
    ALU_XOR    = 5'h06,
    ALU_EQV    = 5'h07,
    ALU_SRL    = 5'h08,
    ALU_SLL    = 5'h09,
    ALU_SRA    = 5'h0a,
    ALU_CMPULT = 5'h0b,
    ALU_CMPEQ  = 5'h0c,
    ALU_CMPULE = 5'h0d,
    ALU_CMPLT  = 5'h0e,
    ALU_CMPLE  = 5'h0f
  } alu_func_t;

  // Low two bits pick LBC, EQ, LT or LE against zero; bit 2 inverts
  typedef logic [2:0] br_func_t;

  typedef enum logic [1:0] {
    BRANCH_NONE      = 2'b00,
    BRANCH_TAKEN     = 2'b01,
    BRANCH_NOT_TAKEN = 2'b10,
    BRANCH_HALT      = 2'b11
  } branch_result_t;

  typedef struct packed {
    logic [31:0]             ir;
    logic [XLEN-1:0]         npc;
    logic [REG_BITS-1:0]     dest_reg;
    logic [XLEN-1:0]         opa;
    logic [XLEN-1:0]         opb;
    alu_func_t               alu_func;
    br_func_t                br_func;
    logic                    is_branch;
    logic                    pred_taken;
    logic                    is_mult;
    logic [HISTORY_BITS-1:0] pht_idx;
    logic                    valid;
  } ex_issue_t;

  // Rides along the multiplier pipe next to the partial products
  typedef struct packed {
    logic [XLEN-1:0]     npc;
    logic [REG_BITS-1:0] dest_reg;
  } mult_tag_t;

  typedef struct packed {
    logic [31:0]             ir;
    logic [XLEN-1:0]         npc;
    logic [REG_BITS-1:0]     dest_reg;
    logic [XLEN-1:0]         alu_result;
    logic                    alu_valid;
    logic                    branch_valid;
    logic                    branch_taken;
    logic                    mispredict;
    logic [HISTORY_BITS-1:0] pht_idx;
  } lane_result_t;

  typedef struct packed {
    mult_tag_t       tag;
    logic [XLEN-1:0] product;
    logic            valid;
  } mult_result_t;

  typedef struct packed {
    logic [REG_BITS-1:0] tag;
    logic [XLEN-1:0]     value;
    logic                valid;
  } mem_result_t;

  typedef struct packed {
    logic [XLEN-1:0]         npc;
    logic [REG_BITS-1:0]     dest_reg;
    logic [XLEN-1:0]         result;
    logic                    mispredict;
    branch_result_t          branch_result;
    logic [HISTORY_BITS-1:0] pht_idx;
    logic                    valid;
  } ex_result_t;

endpackage

/* source/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  ex_issue_t   issue_1,
  input  ex_issue_t   issue_2,
  input  mem_result_t mem_in,
  output ex_result_t  result_1,
  output ex_result_t  result_2,
  output logic        stall_1,
  output logic        stall_2
);

  lane_result_t lane_1;
  lane_result_t lane_2;
  logic         mult_start_1;
  logic         mult_start_2;
  mult_tag_t    mult_tag_1;
  mult_tag_t    mult_tag_2;
  mult_result_t mult_1;
  mult_result_t mult_2;
  logic         hold_mult_2;

  ex_lane lane_1_inst (
    .issue      (issue_1),
    .stall      (stall_1),
    .lane       (lane_1),
    .mult_start (mult_start_1),
    .mult_tag   (mult_tag_1)
  );

  ex_lane lane_2_inst (
    .issue      (issue_2),
    .stall      (stall_2),
    .lane       (lane_2),
    .mult_start (mult_start_2),
    .mult_tag   (mult_tag_2)
  );

  // Bus 1 has no load input, so its multiplier never freezes
  mult mult_1_inst (
    .clock  (clock),
    .reset  (reset),
    .hold   (1'b0),
    .start  (mult_start_1),
    .mplier (issue_1.opb),
    .mcand  (issue_1.opa),
    .tag_in (mult_tag_1),
    .out    (mult_1)
  );

  mult mult_2_inst (
    .clock  (clock),
    .reset  (reset),
    .hold   (hold_mult_2),
    .start  (mult_start_2),
    .mplier (issue_2.opb),
    .mcand  (issue_2.opa),
    .tag_in (mult_tag_2),
    .out    (mult_2)
  );

  ex_arbiter arbiter_inst (
    .lane_1      (lane_1),
    .lane_2      (lane_2),
    .mult_1      (mult_1),
    .mult_2      (mult_2),
    .mem_in      (mem_in),
    .result_1    (result_1),
    .result_2    (result_2),
    .stall_1     (stall_1),
    .stall_2     (stall_2),
    .hold_mult_2 (hold_mult_2)
  );

endmodule

/* source/mult.sv */
`timescale 1ns/1ps

module mult
  import ex_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            hold,
  input  logic            start,
  input  logic [XLEN-1:0] mplier,
  input  logic [XLEN-1:0] mcand,
  input  mult_tag_t       tag_in,
  output mult_result_t    out
);

  // Entry 0 feeds the first stage, entry MULT_STAGES leaves the last
  logic [XLEN-1:0] products [MULT_STAGES+1];
  logic [XLEN-1:0] mpliers  [MULT_STAGES+1];
  logic [XLEN-1:0] mcands   [MULT_STAGES+1];
  mult_tag_t       tags     [MULT_STAGES+1];
  logic            dones    [MULT_STAGES+1];

  assign products[0] = '0;
  assign mpliers[0]  = mplier;
  assign mcands[0]   = mcand;
  assign tags[0]     = tag_in;
  assign dones[0]    = start;

  for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
    mult_stage stage_inst (
      .clock       (clock),
      .reset       (reset),
      .hold        (hold),
      .start       (dones[i]),
      .product_in  (products[i]),
      .mplier_in   (mpliers[i]),
      .mcand_in    (mcands[i]),
      .tag_in      (tags[i]),
      .product_out (products[i+1]),
      .mplier_out  (mpliers[i+1]),
      .mcand_out   (mcands[i+1]),
      .tag_out     (tags[i+1]),
      .done        (dones[i+1])
    );
  end

  assign out.tag     = tags[MULT_STAGES];
  assign out.product = products[MULT_STAGES];
  assign out.valid   = dones[MULT_STAGES];

endmodule

/* source/mult_stage.sv */
`timescale 1ns/1ps

module mult_stage
  import ex_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            hold,
  input  logic            start,
  input  logic [XLEN-1:0] product_in,
  input  logic [XLEN-1:0] mplier_in,
  input  logic [XLEN-1:0] mcand_in,
  input  mult_tag_t       tag_in,
  output logic [XLEN-1:0] product_out,
  output logic [XLEN-1:0] mplier_out,
  output logic [XLEN-1:0] mcand_out,
  output mult_tag_t       tag_out,
  output logic            done
);

  logic [XLEN-1:0] prod_reg;
  logic [XLEN-1:0] partial_reg;
  logic [XLEN-1:0] partial_product;

  // One slice of the multiplier times the whole multiplicand
  assign partial_product = mplier_in[SLICE_BITS-1:0] * mcand_in;

  // Accumulate after the register to keep the adder out of the multiply path
  assign product_out = prod_reg + partial_reg;

  always_ff @(posedge clock) begin
    if (!hold) begin
      prod_reg    <= product_in;
      partial_reg <= partial_product;
      mplier_out  <= mplier_in >> SLICE_BITS;
      mcand_out   <= mcand_in << SLICE_BITS;
      tag_out     <= tag_in;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (!hold) begin
      done <= start;
    end
  end

endmodule

/* verif/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int HALF_PERIOD    = 2;
  localparam int RESET_CYCLES   = 10;
  localparam int RANDOM_OPS     = 300;
  localparam int TEST_CYCLES    = RESET_CYCLES + 40 + 3 * RANDOM_OPS;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

  localparam int KIND_ALU    = 0;
  localparam int KIND_BRANCH = 1;
  localparam int KIND_MULT   = 2;
  localparam int KIND_HALT   = 3;

  // Expected multiply result and the check cycle it is due in
  typedef struct packed {
    int         due;
    ex_result_t res;
  } pending_mult_t;

  logic        clock = 1'b0;
  logic        reset;
  ex_issue_t   issue_1;
  ex_issue_t   issue_2;
  mem_result_t mem_in;
  ex_result_t  result_1;
  ex_result_t  result_2;
  logic        stall_1;
  logic        stall_2;

  logic [31:0]   seed = 32'hc764_8997;
  int            cycle = 0;
  bit            accepted_1 = 1'b1;
  bit            accepted_2 = 1'b1;
  ex_issue_t     pend_1[$];
  ex_issue_t     pend_2[$];
  mem_result_t   pend_mem[$];
  pending_mult_t exp_q1[$];
  pending_mult_t exp_q2[$];

  ex_stage uut (
    .clock    (clock),
    .reset    (reset),
    .issue_1  (issue_1),
    .issue_2  (issue_2),
    .mem_in   (mem_in),
    .result_1 (result_1),
    .result_2 (result_2),
    .stall_1  (stall_1),
    .stall_2  (stall_2)
  );

  always #(HALF_PERIOD) clock = ~clock;

  function logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [63:0] ref_alu(logic [63:0] a, logic [63:0] b, alu_func_t f);
    logic [63:0]  flip;
    logic [127:0] ext;
    flip = 64'h8000_0000_0000_0000;
    // Sign-extended copy shifted right gives the arithmetic shift
    ext  = {{64{a[63]}}, a} >> b[5:0];
    case (f)
      ALU_ADDQ:   return a + b;
      ALU_SUBQ:   return a - b;
      ALU_AND:    return a & b;
      ALU_BIC:    return a & ~b;
      ALU_BIS:    return a | b;
      ALU_ORNOT:  return a | ~b;
      ALU_XOR:    return a ^ b;
      ALU_EQV:    return ~(a ^ b);
      ALU_SRL:    return a >> b[5:0];
      ALU_SLL:    return a << b[5:0];
      ALU_SRA:    return ext[63:0];
      ALU_CMPULT: return (a < b) ? 64'd1 : 64'd0;
      ALU_CMPEQ:  return (a == b) ? 64'd1 : 64'd0;
      ALU_CMPULE: return (a <= b) ? 64'd1 : 64'd0;
      // Flipping the sign bit turns a signed compare into an unsigned one
      ALU_CMPLT:  return ((a ^ flip) < (b ^ flip)) ? 64'd1 : 64'd0;
      ALU_CMPLE:  return ((a ^ flip) <= (b ^ flip)) ? 64'd1 : 64'd0;
      default:    return '0;
    endcase
  endfunction

  function automatic logic ref_branch(logic [63:0] a, br_func_t f);
    logic c;
    case (f[1:0])
      2'd0:    c = a[0] == 1'b0;
      2'd1:    c = a == 64'd0;
      2'd2:    c = $signed(a) < 0;
      default: c = $signed(a) <= 0;
    endcase
    return c ^ f[2];
  endfunction

  // Bus contents when the lane owns its bus
  function automatic ex_result_t expect_lane(ex_issue_t i);
    ex_result_t e;
    logic       taken;
    e          = '0;
    taken      = ref_branch(i.opa, i.br_func);
    e.npc      = i.npc;
    e.dest_reg = i.dest_reg;
    e.result   = ref_alu(i.opa, i.opb, i.alu_func);
    e.pht_idx  = i.pht_idx;
    if (!i.valid) begin
      e.valid = 1'b0;
    end else if (i.is_branch) begin
      e.valid         = 1'b1;
      e.branch_result = taken ? BRANCH_TAKEN : BRANCH_NOT_TAKEN;
      e.mispredict    = taken != i.pred_taken;
    end else if (i.ir == HALT_INSTRUCTION) begin
      e.valid         = 1'b1;
      e.branch_result = BRANCH_HALT;
    end else begin
      e.valid = !i.is_mult;
    end
    return e;
  endfunction

  function automatic pending_mult_t make_mult(ex_issue_t i, int due);
    pending_mult_t p;
    p              = '0;
    p.due          = due;
    p.res.npc      = i.npc;
    p.res.dest_reg = i.dest_reg;
    p.res.result   = i.opa * i.opb;
    p.res.valid    = 1'b1;
    return p;
  endfunction

  function automatic ex_issue_t random_issue(int kind);
    ex_issue_t   i;
    logic [31:0] r;
    r            = next_rand();
    i.ir         = next_rand() | 32'h8000_0000;
    i.npc        = {next_rand(), next_rand()};
    i.opa        = {next_rand(), next_rand()};
    i.opb        = {next_rand(), next_rand()};
    i.dest_reg   = r[4:0];
    i.pht_idx    = r[9:5];
    i.br_func    = r[12:10];
    i.alu_func   = alu_func_t'({1'b0, r[16:13]});
    i.pred_taken = r[17];
    // Zero and equal operands for the EQ tests and compares
    if (r[20:18] == 3'd0) begin
      i.opa = '0;
    end else if (r[20:18] == 3'd1) begin
      i.opb = i.opa;
    end
    if (kind == KIND_HALT) begin
      i.ir = HALT_INSTRUCTION;
    end
    i.is_branch = kind == KIND_BRANCH;
    i.is_mult   = kind == KIND_MULT;
    i.valid     = 1'b1;
    return i;
  endfunction

  function automatic int random_kind();
    int n;
    n = next_rand() % 20;
    if (n < 11) return KIND_ALU;
    if (n < 15) return KIND_BRANCH;
    if (n < 19) return KIND_MULT;
    return KIND_HALT;
  endfunction

  function automatic mem_result_t random_mem(bit valid);
    mem_result_t m;
    logic [31:0] r;
    r       = next_rand();
    m.tag   = r[REG_BITS-1:0];
    m.value = {next_rand(), next_rand()};
    m.valid = valid;
    return m;
  endfunction

  task automatic check(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s actual %h expected %h", name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_bus(string bus, ex_result_t act, ex_result_t exp, bit with_npc);
    check({bus, ".valid"}, act.valid, exp.valid);
    if (exp.valid) begin
      if (with_npc) begin
        check({bus, ".npc"}, act.npc, exp.npc);
      end
      check({bus, ".dest_reg"}, act.dest_reg, exp.dest_reg);
      check({bus, ".result"}, act.result, exp.result);
      check({bus, ".mispredict"}, act.mispredict, exp.mispredict);
      check({bus, ".branch_result"}, act.branch_result, exp.branch_result);
      check({bus, ".pht_idx"}, act.pht_idx, exp.pht_idx);
    end
  endtask

  // Feed queued work, holding a lane's issue while it is stalled
  task automatic run_queued();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clock);
      if (accepted_1) begin
        if (pend_1.size() != 0) issue_1 = pend_1.pop_front();
        else issue_1 = '0;
      end
      if (accepted_2) begin
        if (pend_2.size() != 0) issue_2 = pend_2.pop_front();
        else issue_2 = '0;
      end
      if (pend_mem.size() != 0) mem_in = pend_mem.pop_front();
      else mem_in = '0;
      busy = pend_1.size() != 0 || pend_2.size() != 0 || pend_mem.size() != 0 ||
             issue_1.valid || issue_2.valid || mem_in.valid ||
             exp_q1.size() != 0 || exp_q2.size() != 0;
    end
  endtask

  always @(posedge clock) begin
    ex_result_t    exp_1;
    ex_result_t    exp_2;
    pending_mult_t head;
    logic          due_1;
    logic          due_2;
    logic          stall_exp_2;
    if (!reset) begin
      due_1 = exp_q1.size() != 0 && exp_q1[0].due == cycle;
      if (due_1) begin
        head          = exp_q1.pop_front();
        exp_1         = head.res;
        exp_1.pht_idx = issue_1.pht_idx;
      end else begin
        exp_1 = expect_lane(issue_1);
      end
      check("stall_1", stall_1, due_1);
      check_bus("result_1", result_1, exp_1, 1'b1);
      if (issue_1.valid && issue_1.is_mult && !due_1) begin
        exp_q1.push_back(make_mult(issue_1, cycle + MULT_STAGES));
      end
      accepted_1 = !due_1;

      due_2       = exp_q2.size() != 0 && exp_q2[0].due == cycle;
      stall_exp_2 = mem_in.valid || due_2;
      if (mem_in.valid) begin
        exp_2          = '0;
        exp_2.valid    = 1'b1;
        exp_2.dest_reg = mem_in.tag;
        exp_2.result   = mem_in.value;
        exp_2.pht_idx  = issue_2.pht_idx;
        // Frozen pipe pushes every multiply in flight back a cycle
        if (due_2) begin
          foreach (exp_q2[k]) begin
            exp_q2[k].due = exp_q2[k].due + 1;
          end
        end
      end else if (due_2) begin
        head          = exp_q2.pop_front();
        exp_2         = head.res;
        exp_2.pht_idx = issue_2.pht_idx;
      end else begin
        exp_2 = expect_lane(issue_2);
      end
      check("stall_2", stall_2, stall_exp_2);
      check_bus("result_2", result_2, exp_2, !mem_in.valid);
      if (issue_2.valid && issue_2.is_mult && !stall_exp_2) begin
        exp_q2.push_back(make_mult(issue_2, cycle + MULT_STAGES));
      end
      accepted_2 = !stall_exp_2;
      cycle++;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * 2 * HALF_PERIOD);
    $display("watchdog expired after %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    issue_1 = '0;
    issue_2 = '0;
    mem_in  = '0;
    reset   = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // Quiet buses after reset
    repeat (3) @(negedge clock);

    // Back-to-back multiplies on lane 1, then an ALU op held behind them
    for (int k = 0; k < 4; k++) pend_1.push_back(random_issue(KIND_MULT));
    pend_1.push_back(random_issue(KIND_ALU));
    // Lane 2 multiply finishing into two load results
    pend_2.push_back(random_issue(KIND_MULT));
    for (int k = 0; k < 4; k++) pend_2.push_back(random_issue(KIND_ALU));
    for (int k = 0; k < 4; k++) pend_mem.push_back(random_mem(1'b0));
    for (int k = 0; k < 2; k++) pend_mem.push_back(random_mem(1'b1));
    run_queued();

    for (int n = 0; n < RANDOM_OPS; n++) begin
      pend_1.push_back(random_issue(random_kind()));
      pend_2.push_back(random_issue(random_kind()));
      pend_mem.push_back(random_mem(next_rand() % 6 == 0));
    end
    run_queued();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
